//--- fft_pkg.sv
package fft_pkg;

	localparam int N_POINTS   = 16;                     // Transform size
	localparam int LOG2_N     = 4;                      // Butterfly stage count
	localparam int IN_W       = 16;                     // Input part width
	localparam int DATA_W     = 20;                     // One growth bit per stage
	localparam int TW_W       = 16;                     // Twiddle part width
	localparam int TW_FRAC    = TW_W - 2;               // Q1.14 fraction bits
	localparam int PROD_W     = DATA_W + TW_W + 1;      // Complex product with carry
	localparam int ROUND_ADD  = 2 ** (TW_FRAC - 1);     // Half LSB of the product
	localparam int N_TW       = 12;                     // Twiddle table entries
	localparam int PIPE_DEPTH = LOG2_N + 1;             // Stage regs plus multiplier reg
	localparam int FILL_COUNT = N_POINTS - 1 + PIPE_DEPTH;
	localparam int FILL_W     = $clog2(FILL_COUNT + 1); // Fill counter width

	// Advance on which sample 0 of the first frame reaches each block.
	// Each hop adds the stage delay plus its output register
	localparam int ARRIVE_S1  = 0;
	localparam int ARRIVE_S2  = ARRIVE_S1 + N_POINTS / 2 + 1;
	localparam int ARRIVE_ROT = ARRIVE_S2 + N_POINTS / 4 + 1;
	localparam int ARRIVE_S3  = ARRIVE_ROT + 1;          // Rotator adds its register only
	localparam int ARRIVE_S4  = ARRIVE_S3 + N_POINTS / 8 + 1;

	typedef logic signed [IN_W-1:0]   in_sample_t;     // Input part
	typedef logic signed [DATA_W-1:0] sample_t;        // Internal and output part
	typedef logic signed [TW_W-1:0]   twiddle_t;       // Q1.14 coefficient part

	// W16^k real part, cos(2*pi*k/16)
	localparam twiddle_t tw_cos [N_TW] = '{
		16384, 15137, 11585, 6270,
		0, -6270, -11585, -15137,
		-16384, -15137, -11585, -6270
	};

	// W16^k imaginary part, -sin(2*pi*k/16)
	localparam twiddle_t tw_sin [N_TW] = '{
		0, -6270, -11585, -15137,
		-16384, -15137, -11585, -6270,
		0, 6270, 11585, 15137
	};

endpackage

//--- sdf_delay_line.sv
`timescale 1ns/1ns

module sdf_delay_line
	import fft_pkg::*;
#(
	parameter int DEPTH = 8                   // Feedback length in samples
)(
	input  logic    CLK,
	input  logic    RST,
	input  logic    adv_i,                     // Shift enable
	input  sample_t wr_re_i,                   // Newest entry
	input  sample_t wr_im_i,
	output sample_t rd_re_o,                   // Oldest entry
	output sample_t rd_im_o
);

	sample_t sr_re [DEPTH];                    // Real part chain
	sample_t sr_im [DEPTH];                    // Imaginary part chain

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				sr_re[i] <= '0;                // Start from an empty memory
				sr_im[i] <= '0;
			end
		end
		else if (adv_i)
		begin
			sr_re[0] <= wr_re_i;
			sr_im[0] <= wr_im_i;
			for (int i = 1; i < DEPTH; i++)
			begin
				sr_re[i] <= sr_re[i-1];        // Move one slot toward the read end
				sr_im[i] <= sr_im[i-1];
			end
		end
	end

	assign rd_re_o = sr_re[DEPTH-1];           // Written DEPTH advances ago
	assign rd_im_o = sr_im[DEPTH-1];

endmodule

//--- sdf_bf_stage.sv
`timescale 1ns/1ns

module sdf_bf_stage
	import fft_pkg::*;
#(
	parameter int DEPTH  = 8,                  // Feedback delay
	parameter bit ROT_J  = 1'b0,               // Apply -j to the last quarter
	parameter int ARRIVE = 0                   // Advance of the first sample of frame 0
)(
	input  logic    CLK,
	input  logic    RST,
	input  logic    adv_i,                     // Pipeline advance
	input  sample_t in_re_i,
	input  sample_t in_im_i,
	output sample_t out_re_o,
	output sample_t out_im_o
);

	localparam int CW = $clog2(2 * DEPTH);     // Phase counter width, modulo 2*DEPTH
	localparam int QB = (CW > 1) ? CW - 2 : 0; // Quarter bit inside the fill half

	logic [CW-1:0] cnt_q;                      // Counts advances since reset
	logic [CW-1:0] phase;                      // Position of the current input in its group
	logic          bf_half;                    // Second half of the group
	logic          rot_j;                      // Output needs -j
	sample_t       mem_re;
	sample_t       mem_im;
	sample_t       wr_re;                      // Value fed back into the memory
	sample_t       wr_im;
	sample_t       fw_re;                      // Value sent forward before rotation
	sample_t       fw_im;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			cnt_q <= '0;
		else if (adv_i)
			cnt_q <= cnt_q + 1'b1;             // Wraps at 2*DEPTH
	end

	// Shift the count so phase 0 lines up with the first sample of a group
	assign phase   = cnt_q - CW'(ARRIVE);
	assign bf_half = phase[CW-1];
	assign rot_j   = ROT_J && !bf_half && phase[QB]; // Differences of the upper pair

	sdf_delay_line #(
		.DEPTH   (DEPTH)
	) u_delay_line (
		.CLK     (CLK),
		.RST     (RST),
		.adv_i   (adv_i),
		.wr_re_i (wr_re),
		.wr_im_i (wr_im),
		.rd_re_o (mem_re),
		.rd_im_o (mem_im)
	);

	always_comb
	begin
		if (bf_half)
		begin
			fw_re = mem_re + in_re_i;          // Sum goes forward
			fw_im = mem_im + in_im_i;
			wr_re = mem_re - in_re_i;          // Difference waits in the memory
			wr_im = mem_im - in_im_i;
		end
		else
		begin
			fw_re = mem_re;                    // Drain the previous differences
			fw_im = mem_im;
			wr_re = in_re_i;                   // Store the first half
			wr_im = in_im_i;
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			out_re_o <= '0;
			out_im_o <= '0;
		end
		else if (adv_i)
		begin
			if (rot_j)
			begin
				out_re_o <= fw_im;             // -j*(a+jb) = b - ja
				out_im_o <= -fw_re;
			end
			else
			begin
				out_re_o <= fw_re;
				out_im_o <= fw_im;
			end
		end
	end

endmodule

//--- twiddle_rotator.sv
`timescale 1ns/1ns

module twiddle_rotator
	import fft_pkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  logic    adv_i,                     // Pipeline advance
	input  sample_t in_re_i,
	input  sample_t in_im_i,
	output sample_t out_re_o,
	output sample_t out_im_o
);

	logic [LOG2_N-1:0] cnt_q;                  // Advances since reset, modulo frame
	logic [LOG2_N-1:0] idx;                    // Sample index inside the frame
	logic [1:0]        pat;                    // Multiplier of the quarter
	logic [3:0]        tw_exp;                 // Exponent of W16
	twiddle_t          w_re;
	twiddle_t          w_im;
	logic signed [PROD_W-1:0] p_re;            // Full precision product
	logic signed [PROD_W-1:0] p_im;
	logic signed [PROD_W-1:0] r_re;            // Rounded back to the data scale
	logic signed [PROD_W-1:0] r_im;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			cnt_q <= '0;
		else if (adv_i)
			cnt_q <= cnt_q + 1'b1;             // Wraps every frame
	end

	assign idx = cnt_q - LOG2_N'(ARRIVE_ROT);  // Align to the first sample of a frame

	// Quarters arrive in bit-reversed k order, so the exponent steps 0, 2, 1, 3
	always_comb
	begin
		case (idx[3:2])
			2'd0:    pat = 2'd0;
			2'd1:    pat = 2'd2;
			2'd2:    pat = 2'd1;
			default: pat = 2'd3;
		endcase
	end

	assign tw_exp = {2'b00, idx[1:0]} * {2'b00, pat}; // At most 9
	assign w_re   = tw_cos[tw_exp];
	assign w_im   = tw_sin[tw_exp];

	// (a+jb)(c+jd) = (ac-bd) + j(ad+bc)
	assign p_re = in_re_i * w_re - in_im_i * w_im;
	assign p_im = in_re_i * w_im + in_im_i * w_re;

	// Round half up, then drop the Q1.14 fraction
	assign r_re = (p_re + ROUND_ADD) >>> TW_FRAC;
	assign r_im = (p_im + ROUND_ADD) >>> TW_FRAC;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			out_re_o <= '0;
			out_im_o <= '0;
		end
		else if (adv_i)
		begin
			out_re_o <= r_re[DATA_W-1:0];      // Magnitude fits, |W| <= 1
			out_im_o <= r_im[DATA_W-1:0];
		end
	end

endmodule

//--- fft_flow_ctrl.sv
`timescale 1ns/1ns

module fft_flow_ctrl
	import fft_pkg::*;
(
	input  logic CLK,
	input  logic RST,
	input  logic in_valid_i,                   // Producer has a sample
	input  logic out_ready_i,                  // Consumer takes a bin
	output logic in_ready_o,
	output logic out_valid_o,
	output logic adv_o                         // Moves the whole data path
);

	logic [FILL_W-1:0] fill_q;                 // Advances so far, saturates at FILL_COUNT
	logic              filled;                 // First bin is at the output

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			fill_q <= '0;
		else if (adv_o && !filled)
			fill_q <= fill_q + 1'b1;
	end

	assign filled = (fill_q == FILL_W'(FILL_COUNT));

	// While filling, the output is not meaningful and the input is always taken.
	// Once filled, one sample in means one bin out, so both sides must agree
	assign in_ready_o  = filled ? out_ready_i : 1'b1;
	assign out_valid_o = filled & in_valid_i;
	assign adv_o       = in_valid_i & in_ready_o;

endmodule

//--- fft16_sdf.sv
`timescale 1ns/1ns

module fft16_sdf
	import fft_pkg::*;
(
	input  logic       CLK,
	input  logic       RST,
	input  logic       in_valid_i,
	output logic       in_ready_o,
	input  in_sample_t in_re_i,
	input  in_sample_t in_im_i,
	output logic       out_valid_o,
	input  logic       out_ready_i,
	output sample_t    out_re_o,               // Bins in bit-reversed order
	output sample_t    out_im_o
);

	logic    adv;                              // Common advance enable
	sample_t x_re;                             // Sign-extended input
	sample_t x_im;
	sample_t s1_re;                            // After the delay 8 stage
	sample_t s1_im;
	sample_t s2_re;                            // After the delay 4 stage
	sample_t s2_im;
	sample_t tw_re;                            // After the twiddle multiply
	sample_t tw_im;
	sample_t s3_re;                            // After the delay 2 stage
	sample_t s3_im;

	assign x_re = sample_t'(in_re_i);
	assign x_im = sample_t'(in_im_i);

	fft_flow_ctrl u_flow_ctrl (
		.CLK         (CLK),
		.RST         (RST),
		.in_valid_i  (in_valid_i),
		.out_ready_i (out_ready_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.adv_o       (adv)
	);

	// First radix-2^2 pair with the trivial -j between its halves
	sdf_bf_stage #(
		.DEPTH    (8),
		.ROT_J    (1'b1),
		.ARRIVE   (ARRIVE_S1)
	) u_bf_d8 (
		.CLK      (CLK),
		.RST      (RST),
		.adv_i    (adv),
		.in_re_i  (x_re),
		.in_im_i  (x_im),
		.out_re_o (s1_re),
		.out_im_o (s1_im)
	);

	sdf_bf_stage #(
		.DEPTH    (4),
		.ROT_J    (1'b0),
		.ARRIVE   (ARRIVE_S2)
	) u_bf_d4 (
		.CLK      (CLK),
		.RST      (RST),
		.adv_i    (adv),
		.in_re_i  (s1_re),
		.in_im_i  (s1_im),
		.out_re_o (s2_re),
		.out_im_o (s2_im)
	);

	twiddle_rotator u_twiddle (
		.CLK      (CLK),
		.RST      (RST),
		.adv_i    (adv),
		.in_re_i  (s2_re),
		.in_im_i  (s2_im),
		.out_re_o (tw_re),
		.out_im_o (tw_im)
	);

	// Second pair forms the 4-point transforms
	sdf_bf_stage #(
		.DEPTH    (2),
		.ROT_J    (1'b1),
		.ARRIVE   (ARRIVE_S3)
	) u_bf_d2 (
		.CLK      (CLK),
		.RST      (RST),
		.adv_i    (adv),
		.in_re_i  (tw_re),
		.in_im_i  (tw_im),
		.out_re_o (s3_re),
		.out_im_o (s3_im)
	);

	sdf_bf_stage #(
		.DEPTH    (1),
		.ROT_J    (1'b0),
		.ARRIVE   (ARRIVE_S4)
	) u_bf_d1 (
		.CLK      (CLK),
		.RST      (RST),
		.adv_i    (adv),
		.in_re_i  (s3_re),
		.in_im_i  (s3_im),
		.out_re_o (out_re_o),
		.out_im_o (out_im_o)
	);

endmodule

//--- fft_flow_assert.sv
`timescale 1ns/1ns

module fft_flow_assert
	import fft_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic in_valid_i,
	input logic out_ready_i,
	input logic in_ready_o,
	input logic out_valid_o,
	input logic adv_o
);

	int adv_seen;                            // Handshakes seen since reset, saturates at fill

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			adv_seen <= 0;
		else if (in_valid_i && in_ready_o && adv_seen < FILL_COUNT)
			adv_seen <= adv_seen + 1;            // Counted from the port handshake
	end

	// A bin leaves only together with a new sample
	a_valid_needs_input: assert property (@(posedge CLK) disable iff (RST)
		out_valid_o |-> in_valid_i)
		else $error("out_valid_o high without in_valid_i");

	a_adv_needs_ready: assert property (@(posedge CLK) disable iff (RST)
		adv_o |-> in_ready_o)
		else $error("adv_o fired while in_ready_o low");

	// Filling never back-pressures the producer
	a_ready_while_filling: assert property (@(posedge CLK) disable iff (RST)
		(adv_seen < FILL_COUNT) |-> (in_ready_o && !out_valid_o))
		else $error("Handshake left the fill state before FILL_COUNT advances");

	a_ready_follows_consumer: assert property (@(posedge CLK) disable iff (RST)
		(adv_seen == FILL_COUNT) |-> (in_ready_o == out_ready_i))
		else $error("in_ready_o does not follow out_ready_i after the fill");

endmodule

bind fft_flow_ctrl fft_flow_assert u_flow_assert (
	.CLK         (CLK),
	.RST         (RST),
	.in_valid_i  (in_valid_i),
	.out_ready_i (out_ready_i),
	.in_ready_o  (in_ready_o),
	.out_valid_o (out_valid_o),
	.adv_o       (adv_o)
);

//--- tb_fft16_sdf.sv
`timescale 1ns/1ns

module tb_fft16_sdf
	import fft_pkg::*;
();

	localparam int  CLK_HALF = 4;               // 8 ns period
	localparam int  WAIT_MAX = 200;             // Cycles allowed per accepted sample
	localparam int  N_FRAMES = 4;               // Random frames per stream
	localparam int  BIN_TOL  = 6;               // Rounding slack per part
	localparam real PI       = 3.14159265358979;

	logic       CLK;
	logic       RST;
	logic       in_valid;
	logic       in_ready;
	in_sample_t in_re;
	in_sample_t in_im;
	logic       out_valid;
	logic       out_ready;
	sample_t    out_re;
	sample_t    out_im;

	integer     seed;
	string      test_name;
	logic       use_stalls;                 // Random gaps and back-pressure
	int         adv_cnt;                    // Advances since the last reset
	int         stim_re [$];                // Frame data of the current stream
	int         stim_im [$];
	int         drv_re [$];                 // Every sample taken since reset
	int         drv_im [$];
	sample_t    got_re [$];                 // Every bin transferred since reset
	sample_t    got_im [$];
	sample_t    ref_re [$];                 // Bins of the unstalled random run
	sample_t    ref_im [$];

	fft16_sdf u_fft16_sdf (
		.CLK         (CLK),
		.RST         (RST),
		.in_valid_i  (in_valid),
		.in_ready_o  (in_ready),
		.in_re_i     (in_re),
		.in_im_i     (in_im),
		.out_valid_o (out_valid),
		.out_ready_i (out_ready),
		.out_re_o    (out_re),
		.out_im_o    (out_im)
	);

	initial
	begin
		CLK = 1'b0;
		forever #CLK_HALF CLK = ~CLK;
	end

	task automatic report_failure(input string reason);
		$display("** FAIL **");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_sample(input string what, input sample_t exp_re, input sample_t exp_im,
		input sample_t act_re, input sample_t act_im, input int tol);
		int d_re;
		int d_im;
		d_re = int'(act_re) - int'(exp_re);
		d_im = int'(act_im) - int'(exp_im);
		if (d_re < 0)
			d_re = -d_re;
		if (d_im < 0)
			d_im = -d_im;
		if (d_re > tol || d_im > tol)
		begin
			$display("ERR %s %s: expected %0d %0dj, actual %0d %0dj",
				test_name, what, exp_re, exp_im, act_re, act_im);
			report_failure("Bin value mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
			report_failure("Handshake flag mismatch");
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp)
		begin
			$display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
			report_failure("Transfer count mismatch");
		end
	endtask

	function automatic int bit_reverse(input int p);
		return {p[0], p[1], p[2], p[3]};        // 16 points, 4 index bits
	endfunction

	function automatic sample_t round_to_sample(input real x);
		return sample_t'($rtoi((x >= 0.0) ? x + 0.5 : x - 0.5));
	endfunction

	// X[k] = sum x[n] * exp(-j*2*pi*n*k/16) over frame f, no scaling
	task automatic reference_bin(input int f, input int k, output real re, output real im);
		real ang;
		re = 0.0;
		im = 0.0;
		for (int n = 0; n < N_POINTS; n++)
		begin
			ang = -2.0 * PI * n * k / N_POINTS;
			re += drv_re[f*N_POINTS+n] * $cos(ang) - drv_im[f*N_POINTS+n] * $sin(ang);
			im += drv_re[f*N_POINTS+n] * $sin(ang) + drv_im[f*N_POINTS+n] * $cos(ang);
		end
	endtask

	// Looks at the values that the next rising edge will see
	task automatic collect_cycle(output logic took);
		@(negedge CLK);
		if (adv_cnt < FILL_COUNT)
		begin
			check_flag("valid while filling", 1'b0, out_valid);
			check_flag("ready while filling", 1'b1, in_ready);
		end
		else
		begin
			check_flag("ready follows consumer", out_ready, in_ready);
			check_flag("valid follows producer", in_valid, out_valid);
		end
		if (out_valid && out_ready)
		begin
			got_re.push_back(out_re);
			got_im.push_back(out_im);
		end
		took = in_valid && in_ready;
		if (took)
			adv_cnt++;
	endtask

	task automatic push_sample(input int re, input int im);
		int   tries;
		logic took;
		logic v;
		logic r;
		tries = 0;
		took  = 1'b0;
		while (!took)
		begin
			v = 1'b1;
			r = 1'b1;
			if (use_stalls)
			begin
				v = (($random(seed) & 3) != 0);  // Gap in about one cycle of four
				r = (($random(seed) & 3) != 0);
			end
			@(posedge CLK);
			in_valid  <= v;
			out_ready <= r;
			in_re     <= in_sample_t'(re);
			in_im     <= in_sample_t'(im);
			collect_cycle(took);
			tries++;
			if (!took && tries >= WAIT_MAX)
			begin
				$display("Timeout in %s: sample not taken after %0d cycles", test_name, tries);
				report_failure("Input never accepted");
			end
		end
		drv_re.push_back(re);
		drv_im.push_back(im);
	endtask

	task automatic reset_dut();
		@(posedge CLK);
		RST       <= 1'b1;
		in_valid  <= 1'b0;
		out_ready <= 1'b0;
		repeat (3) @(posedge CLK);
		RST <= 1'b0;
		adv_cnt = 0;
		drv_re.delete();
		drv_im.delete();
		got_re.delete();
		got_im.delete();
		@(negedge CLK);
		check_flag("valid after reset", 1'b0, out_valid);
		check_flag("ready after reset", 1'b1, in_ready);
	endtask

	task automatic verify_outputs();
		real e_re;
		real e_im;
		check_count("bin count", drv_re.size() - FILL_COUNT, got_re.size());
		foreach (got_re[t])
		begin
			reference_bin(t / N_POINTS, bit_reverse(t % N_POINTS), e_re, e_im);
			check_sample($sformatf("bin %0d", t), round_to_sample(e_re), round_to_sample(e_im),
				got_re[t], got_im[t], BIN_TOL);
		end
	endtask

	// Two zero frames carry the last bins past the fill latency
	task automatic run_stream();
		foreach (stim_re[i])
			push_sample(stim_re[i], stim_im[i]);
		repeat (2 * N_POINTS) push_sample(0, 0);
		@(posedge CLK);
		in_valid  <= 1'b0;
		out_ready <= 1'b0;
		verify_outputs();
	endtask

	task automatic load_random(input int n);
		stim_re.delete();
		stim_im.delete();
		repeat (n)
		begin
			stim_re.push_back($random(seed) % 8192); // Keeps 16x growth inside DATA_W
			stim_im.push_back($random(seed) % 8192);
		end
	endtask

	task automatic test_reset_state();
		test_name = "reset_state";
		reset_dut();
		repeat (FILL_COUNT) push_sample(0, 0);
		check_count("bins before fill", 0, got_re.size());
		push_sample(0, 0);
		check_count("bins after fill", 1, got_re.size());
	endtask

	task automatic test_impulse();
		test_name = "impulse";
		reset_dut();
		stim_re = '{1000, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		stim_im = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		run_stream();
		for (int p = 0; p < N_POINTS; p++)
			check_sample($sformatf("flat bin %0d", p), 1000, 0, got_re[p], got_im[p], BIN_TOL);
	endtask

	task automatic test_tone();
		test_name = "tone_bin3";
		reset_dut();
		stim_re.delete();
		stim_im.delete();
		for (int n = 0; n < N_POINTS; n++)
		begin
			stim_re.push_back($rtoi(2000.0 * $cos(2.0 * PI * 3 * n / N_POINTS) + 2000.5) - 2000);
			stim_im.push_back($rtoi(2000.0 * $sin(2.0 * PI * 3 * n / N_POINTS) + 2000.5) - 2000);
		end
		run_stream();
		check_flag("peak at reversed 3", 1'b1, got_re[bit_reverse(3)] > 30000);
	endtask

	task automatic test_random_frames();
		test_name = "random_frames";
		reset_dut();
		load_random(N_FRAMES * N_POINTS);
		run_stream();
		ref_re = got_re;                        // Kept for the stalled rerun
		ref_im = got_im;
	endtask

	task automatic test_random_stalls();
		test_name  = "random_stalls";
		use_stalls = 1'b1;
		reset_dut();
		run_stream();                           // Same frames as the unstalled run
		use_stalls = 1'b0;
		check_count("stalled bin count", ref_re.size(), got_re.size());
		foreach (ref_re[t])
			check_sample($sformatf("rerun bin %0d", t), ref_re[t], ref_im[t],
				got_re[t], got_im[t], 0);
	endtask

	task automatic test_mid_frame_reset();
		test_name = "mid_frame_reset";
		reset_dut();
		repeat (7) push_sample($random(seed) % 8192, $random(seed) % 8192);
		reset_dut();                            // Partial frame is dropped
		load_random(N_POINTS);
		run_stream();
	endtask

	initial
	begin
		seed       = 32'h2e166abd;
		RST        = 1'b1;
		in_valid   = 1'b0;
		out_ready  = 1'b0;
		in_re      = '0;
		in_im      = '0;
		use_stalls = 1'b0;
		adv_cnt    = 0;
		test_reset_state();
		test_impulse();
		test_tone();
		test_random_frames();
		test_random_stalls();
		test_mid_frame_reset();
		$display("** PASS **");
		$finish;
	end

endmodule

//--- build.f
fft_pkg.sv
sdf_delay_line.sv
sdf_bf_stage.sv
twiddle_rotator.sv
fft_flow_ctrl.sv
fft16_sdf.sv
fft_flow_assert.sv
tb_fft16_sdf.sv
